// File: Makefile
VERILATOR ?= verilator
TOP       ?= pet_tb
RTL_TOP   ?= pet_top
FILELIST  ?= tamagotchi.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/pet_checks.svh
`ifndef PET_CHECKS_SVH
`define PET_CHECKS_SVH

// Expected level of one need. Feeds land before its first decay tick and
// toggles come after the last one, since decay is paused in test mode
function automatic pet_pkg::level_t ref_level(input pet_pkg::level_t start, input int n_feed,
                                              input int n_toggle, input int n_cyc,
                                              input int period);
    int lvl;
    lvl = int'(start) + n_feed;
    if (lvl > int'(pet_pkg::LEVEL_MAX)) begin
        lvl = int'(pet_pkg::LEVEL_MAX);          // Feed saturates
    end
    lvl = lvl - n_cyc / period;                  // One step per full period
    if (lvl < 0) begin
        lvl = 0;                                 // Floor at empty
    end
    for (int t = 0; t < n_toggle; t++) begin
        if (lvl == int'(pet_pkg::TEST_LOW)) begin
            lvl = int'(pet_pkg::TEST_HIGH);
        end else begin
            lvl = int'(pet_pkg::TEST_LOW);
        end
    end
    return pet_pkg::level_t'(lvl);
endfunction

task automatic check_level(input string name, input pet_pkg::level_t exp,
                           input pet_pkg::level_t act);
    chk_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("ERR %s: expected level %0d, actual %0d at %0t", name, exp, act, $time);
    end
endtask

task automatic check_need(input string name, input pet_pkg::need_t exp,
                          input pet_pkg::need_t act);
    chk_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("ERR %s: expected need %0d, actual %0d at %0t", name, exp, act, $time);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
        err_cnt++;
        $display("ERR %s: expected %b, actual %b at %0t", name, exp, act, $time);
    end
endtask

`endif

// File: bench/pet_tb.sv
`timescale 1ns/1ps

module pet_tb;

    localparam int CLK_NS   = 20;
    localparam int TAP_CYC  = 13;    // 3 held, 10 idle
    localparam int LONG_CYC = 30;    // 20 held, 10 idle
    localparam int N_RAND   = 6;     // Random selection taps
    localparam int ROUNDS   = 4;     // Decay sampling rounds
    localparam int IDLE_CYC = 300;   // Paused wait in test mode
    localparam int PLAN_CYC = 8 + (3 + N_RAND + 8) * TAP_CYC
                            + ROUNDS * (4 * TAP_CYC + 340) + 3 * LONG_CYC + IDLE_CYC;

    bit              clk;
    logic            rst_n;
    logic [3:0]      btn_need;       // Health, energy, hunger, fun
    logic            btn_reset;
    logic            btn_test;
    pet_pkg::need_t  need_sel;
    pet_pkg::level_t level;
    logic            happy;
    logic            test_mode;

    int              err_cnt;
    int              chk_cnt;
    int              cyc;            // Rising edges so far
    int              anchor;         // Edge where decay counters last restarted
    int              frozen;         // Elapsed count held while paused
    bit              paused;         // Expected mode
    integer          seed;
    pet_pkg::need_t  cur;            // Expected selection
    int              feeds [4];
    int              toggles [4];

    `include "pet_checks.svh"

    always #(CLK_NS / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    pet_top i_pet_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .btn_health (btn_need[0]),
        .btn_energy (btn_need[1]),
        .btn_hunger (btn_need[2]),
        .btn_fun    (btn_need[3]),
        .btn_reset  (btn_reset),
        .btn_test   (btn_test),
        .need_sel   (need_sel),
        .level      (level),
        .happy      (happy),
        .test_mode  (test_mode)
    );

    function automatic int elapsed();
        return paused ? frozen : cyc - anchor;   // Normal-mode edges since restart
    endfunction

    function automatic int period_of(input pet_pkg::need_t n);
        case (n)
            2'd0:    return int'(pet_pkg::DECAY_HEALTH);
            2'd1:    return int'(pet_pkg::DECAY_ENERGY);
            2'd2:    return int'(pet_pkg::DECAY_HUNGER);
            default: return int'(pet_pkg::DECAY_FUN);
        endcase
    endfunction

    task automatic clear_events();
        for (int i = 0; i < 4; i++) begin
            feeds[i]   = 0;
            toggles[i] = 0;
        end
    endtask

    // Tap a need button and track what the press means
    task automatic press_need(input pet_pkg::need_t n);
        if (n != cur) begin
            cur = n;                             // Select only
        end else if (paused) begin
            toggles[n]++;
        end else begin
            feeds[n]++;
        end
        btn_need[n] = 1'b1;
        repeat (3) @(negedge clk);
        btn_need[n] = 1'b0;
        repeat (10) @(negedge clk);
    endtask

    // Hold reset or test for len cycles
    task automatic hold_button(input bit is_test, input int len);
        int c0;
        c0        = cyc;
        btn_test  = is_test;
        btn_reset = !is_test;
        repeat (len) @(negedge clk);
        btn_test  = 1'b0;
        btn_reset = 1'b0;
        if (len >= int'(pet_pkg::HOLD_CYCLES)) begin
            if (is_test) begin
                frozen = c0 + int'(pet_pkg::HOLD_CYCLES) + 3 - anchor;  // Counters stop
                paused = 1'b1;
            end else begin
                if (paused) begin
                    anchor = c0 + int'(pet_pkg::HOLD_CYCLES) + 3;      // Counters restart
                end
                paused = 1'b0;
                cur    = '0;
                clear_events();
            end
        end
        repeat (10) @(negedge clk);
    endtask

    // Wait mid-period, away from tick edges, then compare all outputs
    task automatic check_now(input string name);
        int              p;
        pet_pkg::level_t exp;
        p = period_of(cur);
        while (!paused && (elapsed() % p < p / 4 || elapsed() % p > 3 * p / 4)) begin
            @(negedge clk);
        end
        exp = ref_level(pet_pkg::LEVEL_INIT, feeds[cur], toggles[cur], elapsed(), p);
        check_need(name, cur, need_sel);
        check_level(name, exp, level);
        check_flag({name, " happy"}, exp >= pet_pkg::HAPPY_MIN, happy);
        check_flag({name, " mode"}, paused, test_mode);
    endtask

    initial begin
        pet_pkg::need_t n;
        rst_n     = 1'b0;
        btn_need  = '0;
        btn_reset = 1'b0;
        btn_test  = 1'b0;
        seed      = 32'h32c51cee;
        paused    = 1'b0;
        cur       = '0;
        frozen    = 0;
        anchor    = 0;
        clear_events();
        repeat (4) @(negedge clk);
        rst_n  = 1'b1;
        anchor = cyc;                            // Counting starts on the next edge
        check_now("reset state");
        repeat (3) begin
            press_need(2'd0);                    // Health already selected, so feeds
            check_now("feed health");
        end
        repeat (N_RAND) begin
            n = pet_pkg::need_t'(int'(cur) + 1 + int'($unsigned($random(seed)) % 3));
            press_need(n);                       // Always a different need
            check_now("random select");
        end
        for (int r = 0; r < ROUNDS; r++) begin
            for (int k = 3; k >= 0; k--) begin
                if (cur != pet_pkg::need_t'(k)) begin
                    press_need(pet_pkg::need_t'(k));
                end
                check_now("decay");
            end
        end
        press_need(2'd3);                        // Fun is empty by now
        hold_button(1'b1, 20);
        check_now("test entry");
        repeat (3) begin
            press_need(2'd3);
            check_now("test toggle");
        end
        repeat (IDLE_CYC) @(negedge clk);
        check_now("test paused");
        hold_button(1'b0, 8);                    // Too short to count
        check_now("short reset");
        hold_button(1'b0, 20);
        check_need("long reset select", '0, need_sel);
        check_flag("long reset mode", 1'b0, test_mode);
        for (int k = 3; k >= 0; k--) begin
            press_need(pet_pkg::need_t'(k));
            check_now("long reset level");
        end
        $display("Run complete: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Four times the planned run length
    initial begin
        #(4 * PLAN_CYC * CLK_NS);
        $display("Timeout: the run did not finish within %0d cycles", 4 * PLAN_CYC);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: logic/decay_timer.sv
`timescale 1ns/1ps

module decay_timer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               test_mode,
    output pet_pkg::need_vec_t tick
);

    logic [pet_pkg::DECAY_CNT_W-1:0] period [pet_pkg::NUM_NEEDS];  // Per-need period
    logic [pet_pkg::DECAY_CNT_W-1:0] cnt [pet_pkg::NUM_NEEDS];     // Free-running counts
    pet_pkg::need_vec_t              wrap;                         // Counter at last value

    assign period[0] = pet_pkg::DECAY_HEALTH;
    assign period[1] = pet_pkg::DECAY_ENERGY;
    assign period[2] = pet_pkg::DECAY_HUNGER;
    assign period[3] = pet_pkg::DECAY_FUN;

    always_comb begin
        for (int i = 0; i < pet_pkg::NUM_NEEDS; i++) begin
            wrap[i] = (cnt[i] == period[i] - 8'd1);
        end
    end

    // Counters cleared and frozen in test mode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pet_pkg::NUM_NEEDS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < pet_pkg::NUM_NEEDS; i++) begin
                if (test_mode || wrap[i]) begin
                    cnt[i] <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 8'd1;
                end
            end
        end
    end

    assign tick = test_mode ? '0 : wrap;  // Silent while paused

endmodule

// File: logic/key_scanner.sv
`timescale 1ns/1ps

module key_scanner (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               btn_health,
    input  logic               btn_energy,
    input  logic               btn_hunger,
    input  logic               btn_fun,
    input  logic               btn_reset,
    input  logic               btn_test,
    output pet_pkg::need_vec_t press,
    output logic               hold_reset,
    output logic               hold_test
);

    logic [5:0]         btn_raw;     // All six buttons, need buttons low
    logic [5:0]         btn_meta;    // First sync stage
    logic [5:0]         btn_sync;    // Second sync stage
    pet_pkg::need_vec_t need_prev;   // Need buttons one cycle late
    pet_pkg::need_vec_t need_rise;   // Rising edges this cycle
    pet_pkg::need_vec_t need_first;  // Lowest rising edge only
    logic [1:0]         hold_btn;    // [0] reset, [1] test
    logic [4:0]         hold_cnt [2];
    logic [1:0]         hold_hit;

    assign btn_raw = {btn_test, btn_reset, btn_fun, btn_hunger, btn_energy, btn_health};

    // Two-flop synchronizer on every button
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= btn_raw;
            btn_sync <= btn_meta;
        end
    end

    assign need_rise  = btn_sync[3:0] & ~need_prev;
    assign need_first = need_rise & (~need_rise + 4'd1);  // Isolate lowest set bit

    // Registered edge detect so the press lands on the third edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            need_prev <= '0;
            press     <= '0;
        end else begin
            need_prev <= btn_sync[3:0];
            press     <= need_first;
        end
    end

    assign hold_btn = btn_sync[5:4];

    // Saturating hold counters that pulse once per continuous hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt[0] <= '0;
            hold_cnt[1] <= '0;
            hold_hit    <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!hold_btn[i]) begin
                    hold_cnt[i] <= '0;                   // Release rearms
                end else if (hold_cnt[i] != pet_pkg::HOLD_CYCLES) begin
                    hold_cnt[i] <= hold_cnt[i] + 5'd1;   // Stops at HOLD_CYCLES
                end
                hold_hit[i] <= hold_btn[i] && (hold_cnt[i] == pet_pkg::HOLD_CYCLES - 5'd1);
            end
        end
    end

    assign hold_reset = hold_hit[0];
    assign hold_test  = hold_hit[1];

    a_press_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(press));

endmodule

// File: logic/need_bank.sv
`timescale 1ns/1ps

module need_bank (
    input  logic               clk,
    input  logic               rst_n,
    input  pet_pkg::need_t     sel_need,
    input  logic               feed,
    input  logic               toggle,
    input  logic               reset_all,
    input  pet_pkg::need_vec_t tick,
    input  logic               test_mode,
    output pet_pkg::level_t    level,
    output logic               happy
);

    pet_pkg::level_t lvl [pet_pkg::NUM_NEEDS];  // One level per need

    // Level update, reset_all first, then feed/toggle, then decay
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < pet_pkg::NUM_NEEDS; i++) begin
                lvl[i] <= pet_pkg::LEVEL_INIT;
            end
        end else if (reset_all) begin
            for (int i = 0; i < pet_pkg::NUM_NEEDS; i++) begin
                lvl[i] <= pet_pkg::LEVEL_INIT;
            end
        end else begin
            for (int i = 0; i < pet_pkg::NUM_NEEDS; i++) begin
                if (feed && sel_need == pet_pkg::need_t'(i)) begin
                    if (lvl[i] < pet_pkg::LEVEL_MAX) begin
                        lvl[i] <= lvl[i] + 4'd1;          // Saturating feed
                    end
                end else if (toggle && sel_need == pet_pkg::need_t'(i)) begin
                    if (lvl[i] == pet_pkg::TEST_LOW) begin
                        lvl[i] <= pet_pkg::TEST_HIGH;
                    end else begin
                        lvl[i] <= pet_pkg::TEST_LOW;      // Any other value goes low
                    end
                end else if (tick[i] && lvl[i] != '0) begin
                    lvl[i] <= lvl[i] - 4'd1;              // Decay, floor at 0
                end
            end
        end
    end

    assign level = lvl[sel_need];
    assign happy = (level >= pet_pkg::HAPPY_MIN);

    for (genvar g = 0; g < pet_pkg::NUM_NEEDS; g++) begin : g_lvl_chk
        a_lvl_max: assert property (@(posedge clk) disable iff (!rst_n)
            lvl[g] <= pet_pkg::LEVEL_MAX);
    end

    // Decay must be paused by the timer while in test mode
    a_no_tick_test: assert property (@(posedge clk) disable iff (!rst_n)
        !(test_mode && |tick));

endmodule

// File: logic/pet_control.sv
`timescale 1ns/1ps

module pet_control (
    input  logic               clk,
    input  logic               rst_n,
    input  pet_pkg::need_vec_t press,
    input  logic               hold_reset,
    input  logic               hold_test,
    output pet_pkg::need_t     sel_need,
    output logic               test_mode,
    output logic               feed,
    output logic               toggle,
    output logic               reset_all
);

    pet_pkg::ctrl_state_t state;
    pet_pkg::need_t       press_idx;  // Index of the pressed need
    logic                 press_any;
    logic                 press_sel;  // Press hits the current selection

    // One-hot press to index
    always_comb begin
        press_idx = '0;
        for (int i = 0; i < pet_pkg::NUM_NEEDS; i++) begin
            if (press[i]) begin
                press_idx = pet_pkg::need_t'(i);
            end
        end
    end

    assign press_any = |press;
    assign press_sel = press[sel_need];
    assign test_mode = (state == pet_pkg::ST_TEST);

    // Mode FSM, selection and command pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= pet_pkg::ST_NORMAL;
            sel_need  <= '0;                      // Health
            feed      <= 1'b0;
            toggle    <= 1'b0;
            reset_all <= 1'b0;
        end else begin
            feed      <= 1'b0;                    // Pulses last one cycle
            toggle    <= 1'b0;
            reset_all <= 1'b0;
            if (hold_reset) begin                 // Beats hold_test
                state     <= pet_pkg::ST_NORMAL;
                sel_need  <= '0;
                reset_all <= 1'b1;
            end else begin
                if (hold_test) begin
                    state <= pet_pkg::ST_TEST;
                end
                if (press_any) begin
                    if (press_sel) begin
                        case (state)
                            pet_pkg::ST_NORMAL: feed   <= 1'b1;
                            pet_pkg::ST_TEST:   toggle <= 1'b1;
                            default:            feed   <= 1'b0;
                        endcase
                    end else begin
                        sel_need <= press_idx;    // New need, select only
                    end
                end
            end
        end
    end

    a_cmd_excl: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({feed, toggle, reset_all}));

    a_toggle_test: assert property (@(posedge clk) disable iff (!rst_n)
        toggle |-> (state == pet_pkg::ST_TEST));

endmodule

// File: logic/pet_pkg.sv
package pet_pkg;

    typedef logic [1:0] need_t;      // 0 health, 1 energy, 2 hunger, 3 fun
    typedef logic [3:0] level_t;     // Level of one need, 0..10
    typedef logic [3:0] need_vec_t;  // One bit per need

    // Operating mode of the pet
    typedef enum logic {
        ST_NORMAL = 1'b0,  // Decay runs, repeat press feeds
        ST_TEST   = 1'b1   // Decay paused, repeat press toggles
    } ctrl_state_t;

    localparam int NUM_NEEDS = 4;  // Health, energy, hunger, fun

    localparam level_t LEVEL_INIT = 4'd8;   // Power-up and long-reset level
    localparam level_t LEVEL_MAX  = 4'd10;  // Feed saturates here
    localparam level_t HAPPY_MIN  = 4'd5;   // Happy face from this level up
    localparam level_t TEST_LOW   = 4'd1;   // Test toggle low value
    localparam level_t TEST_HIGH  = 4'd10;  // Test toggle high value

    localparam logic [4:0] HOLD_CYCLES = 5'd16;  // Long-press length in cycles

    localparam int DECAY_CNT_W = 8;  // Decay counter width

    // Decay periods in clock cycles
    localparam logic [DECAY_CNT_W-1:0] DECAY_HEALTH = 8'd120;
    localparam logic [DECAY_CNT_W-1:0] DECAY_ENERGY = 8'd100;
    localparam logic [DECAY_CNT_W-1:0] DECAY_HUNGER = 8'd70;
    localparam logic [DECAY_CNT_W-1:0] DECAY_FUN    = 8'd50;

endpackage

// File: logic/pet_top.sv
`timescale 1ns/1ps

module pet_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            btn_health,
    input  logic            btn_energy,
    input  logic            btn_hunger,
    input  logic            btn_fun,
    input  logic            btn_reset,
    input  logic            btn_test,
    output pet_pkg::need_t  need_sel,
    output pet_pkg::level_t level,
    output logic            happy,
    output logic            test_mode
);

    pet_pkg::need_vec_t press;       // One-cycle need presses
    logic               hold_reset;  // Long reset hold seen
    logic               hold_test;   // Long test hold seen
    logic               feed;
    logic               toggle;
    logic               reset_all;
    pet_pkg::need_vec_t tick;        // Per-need decay strobes

    key_scanner i_key_scanner (
        .clk        (clk),
        .rst_n      (rst_n),
        .btn_health (btn_health),
        .btn_energy (btn_energy),
        .btn_hunger (btn_hunger),
        .btn_fun    (btn_fun),
        .btn_reset  (btn_reset),
        .btn_test   (btn_test),
        .press      (press),
        .hold_reset (hold_reset),
        .hold_test  (hold_test)
    );

    pet_control i_pet_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .press      (press),
        .hold_reset (hold_reset),
        .hold_test  (hold_test),
        .sel_need   (need_sel),
        .test_mode  (test_mode),
        .feed       (feed),
        .toggle     (toggle),
        .reset_all  (reset_all)
    );

    decay_timer i_decay_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .test_mode  (test_mode),
        .tick       (tick)
    );

    need_bank i_need_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel_need   (need_sel),
        .feed       (feed),
        .toggle     (toggle),
        .reset_all  (reset_all),
        .tick       (tick),
        .test_mode  (test_mode),
        .level      (level),
        .happy      (happy)
    );

endmodule

// File: tamagotchi.f
+incdir+bench
logic/pet_pkg.sv
logic/key_scanner.sv
logic/pet_control.sv
logic/decay_timer.sv
logic/need_bank.sv
logic/pet_top.sv
bench/pet_tb.sv
